//--- common/csr_pkg.sv
// CSR types and constants
`default_nettype none

package csr_pkg;

  typedef logic [63:0] xlen_t;     // Machine data word
  typedef logic [11:0] csr_addr_t;
  typedef logic [1:0]  csr_op_t;

  // Operation codes, folded by the decoder from csrrw/csrrs/csrrc and the imm forms
  localparam csr_op_t CSR_OP_RW = 2'd0;  // Write operand
  localparam csr_op_t CSR_OP_RS = 2'd1;  // Set operand bits
  localparam csr_op_t CSR_OP_RC = 2'd2;  // Clear operand bits
  localparam csr_op_t CSR_OP_RD = 2'd3;  // Read only

  // Machine-mode register map
  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MISA      = 12'h301;
  localparam csr_addr_t ADDR_MIE       = 12'h304;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t ADDR_MIP       = 12'h344;
  localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

  // Reset values
  localparam xlen_t RST_MSTATUS = 64'h1888;  // MPP=M, MPIE and MIE set
  localparam xlen_t RST_MIE     = 64'h888;
  localparam xlen_t RST_MIP     = 64'h80;

  // MXL=2 for RV64, only the I extension bit
  localparam xlen_t MISA_VALUE  = {2'b10, 53'd0, 1'b1, 8'd0};

endpackage

`default_nettype wire

//--- common/trap_pkg.sv
// Trap constants
`default_nettype none

package trap_pkg;

  typedef logic [63:0] cause_t;

  // Exception code for a bad CSR access
  localparam cause_t CAUSE_ILLEGAL_INSTR = 64'd2;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;  // MPP is two bits wide

  // Privilege encoding of machine mode
  localparam logic [1:0] PRIV_M = 2'b11;

  // Direct mode only, so the low two mode bits are dropped
  localparam logic [63:0] MTVEC_BASE_MASK = 64'hFFFF_FFFF_FFFF_FFFC;

endpackage

`default_nettype wire

//--- common/csr_trap_if.sv
// Register and trap update bus
`default_nettype none

interface csr_trap_if
  import csr_pkg::*, trap_pkg::*;
();

  // Current register values from the register block
  xlen_t  mstatus;
  xlen_t  mtvec;
  xlen_t  mepc;

  // Update strobes and data from the trap controller
  logic   trap_wr;     // Trap entry, loads all four registers
  logic   mret_wr;     // mret, loads mstatus only
  xlen_t  new_mstatus;
  xlen_t  new_mepc;
  cause_t new_mcause;
  xlen_t  new_mtval;

  modport reg_side (
    output mstatus, mtvec, mepc,
    input  trap_wr, mret_wr, new_mstatus, new_mepc, new_mcause, new_mtval
  );

  modport trap_side (
    input  mstatus, mtvec, mepc,
    output trap_wr, mret_wr, new_mstatus, new_mepc, new_mcause, new_mtval
  );

endinterface

`default_nettype wire

//--- csr/csr_file.sv
// Machine CSR register file
`default_nettype none

module csr_file
  import csr_pkg::*, trap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire csr_addr_t rd_addr,
  output xlen_t          rd_data,
  output logic           rd_hit,
  output logic           rd_only,
  input  wire logic      wr_en,
  input  wire xlen_t     wr_data,
  input  wire logic      kill,
  csr_trap_if.reg_side   trap
);

  xlen_t  mstatus_q;
  xlen_t  mie_q;
  xlen_t  mtvec_q;
  xlen_t  mscratch_q;
  xlen_t  mepc_q;
  cause_t mcause_q;
  xlen_t  mtval_q;
  xlen_t  mip_q;
  xlen_t  mcycle_q;

  logic csr_we;  // CSR write that survives the trap controller
  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;
  logic wr_mscratch;
  logic wr_mepc;
  logic wr_mcause;
  logic wr_mtval;
  logic wr_mip;
  logic wr_mcycle;

  // Write address is the same as the read address, one access per cycle
  assign csr_we      = wr_en & ~kill;
  assign wr_mstatus  = csr_we && (rd_addr == ADDR_MSTATUS);
  assign wr_mie      = csr_we && (rd_addr == ADDR_MIE);
  assign wr_mtvec    = csr_we && (rd_addr == ADDR_MTVEC);
  assign wr_mscratch = csr_we && (rd_addr == ADDR_MSCRATCH);
  assign wr_mepc     = csr_we && (rd_addr == ADDR_MEPC);
  assign wr_mcause   = csr_we && (rd_addr == ADDR_MCAUSE);
  assign wr_mtval    = csr_we && (rd_addr == ADDR_MTVAL);
  assign wr_mip      = csr_we && (rd_addr == ADDR_MIP);
  assign wr_mcycle   = csr_we && (rd_addr == ADDR_MCYCLE);

  // mstatus takes both trap entry and mret updates
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= RST_MSTATUS;
    end else if (trap.trap_wr || trap.mret_wr) begin
      mstatus_q <= trap.new_mstatus;
    end else if (wr_mstatus) begin
      mstatus_q <= wr_data;
    end
  end

  // Trap state, loaded on trap entry ahead of any CSR write
  always_ff @(posedge clk) begin
    if (rst) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap.trap_wr) begin
      mepc_q   <= trap.new_mepc;
      mcause_q <= trap.new_mcause;
      mtval_q  <= trap.new_mtval;
    end else begin
      if (wr_mepc) mepc_q <= wr_data;
      if (wr_mcause) mcause_q <= wr_data;
      if (wr_mtval) mtval_q <= wr_data;
    end
  end

  // Plain software registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q      <= RST_MIE;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mip_q      <= RST_MIP;  // No interrupt sampling, software view only
    end else begin
      if (wr_mie) mie_q <= wr_data;
      if (wr_mtvec) mtvec_q <= wr_data;
      if (wr_mscratch) mscratch_q <= wr_data;
      if (wr_mip) mip_q <= wr_data;
    end
  end

  // Free running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q <= '0;
    end else if (wr_mcycle) begin
      mcycle_q <= wr_data;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  // Read port shows the value before this cycle's write
  always_comb begin
    rd_data = '0;
    rd_hit  = 1'b1;
    rd_only = 1'b0;
    case (rd_addr)
      ADDR_MSTATUS:  rd_data = mstatus_q;
      ADDR_MISA: begin
        rd_data = MISA_VALUE;
        rd_only = 1'b1;
      end
      ADDR_MIE:      rd_data = mie_q;
      ADDR_MTVEC:    rd_data = mtvec_q;
      ADDR_MSCRATCH: rd_data = mscratch_q;
      ADDR_MEPC:     rd_data = mepc_q;
      ADDR_MCAUSE:   rd_data = mcause_q;
      ADDR_MTVAL:    rd_data = mtval_q;
      ADDR_MIP:      rd_data = mip_q;
      ADDR_MCYCLE:   rd_data = mcycle_q;
      // ID registers are hardwired to zero
      ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID: rd_only = 1'b1;
      default:       rd_hit = 1'b0;
    endcase
  end

  assign trap.mstatus = mstatus_q;
  assign trap.mtvec   = mtvec_q;
  assign trap.mepc    = mepc_q;

endmodule

`default_nettype wire

//--- csr/csr_op_unit.sv
// CSR read-modify-write
`default_nettype none

module csr_op_unit
  import csr_pkg::*;
(
  input  wire logic    csr_valid,
  input  wire csr_op_t csr_op,
  input  wire xlen_t   csr_src,
  input  wire xlen_t   old_value,
  input  wire logic    rd_hit,
  input  wire logic    rd_only,
  output logic         wr_en,
  output xlen_t        wr_data,
  output logic         illegal
);

  logic set_clr;  // Set or clear form
  logic writes;   // Access would modify the register

  always_comb begin
    case (csr_op)
      CSR_OP_RW: wr_data = csr_src;
      CSR_OP_RS: wr_data = old_value | csr_src;
      CSR_OP_RC: wr_data = old_value & ~csr_src;
      default:   wr_data = old_value;
    endcase
  end

  // csrrs/csrrc with a zero operand only read, as does CSR_OP_RD
  assign set_clr = (csr_op == CSR_OP_RS) || (csr_op == CSR_OP_RC);
  assign writes  = (csr_op == CSR_OP_RW) || (set_clr && (csr_src != '0));

  // Unmapped address, or a write to misa or an ID register
  assign illegal = csr_valid & (~rd_hit | (rd_only & writes));

  assign wr_en = csr_valid & writes & ~illegal;

endmodule

`default_nettype wire

//--- design/trap_ctrl.sv
// Trap and mret controller
`default_nettype none

module trap_ctrl
  import csr_pkg::*, trap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      trap_req,
  input  wire logic      mret_req,
  input  wire logic      illegal,
  input  wire cause_t    trap_cause,
  input  wire xlen_t     instr_pc,
  input  wire xlen_t     trap_tval,
  input  wire csr_addr_t csr_addr,
  output logic           kill,
  output logic           redirect_valid,
  output xlen_t          redirect_pc,
  csr_trap_if.trap_side  regs
);

  logic  take_entry;  // Pipeline trap or illegal CSR access
  logic  take_mret;
  xlen_t entry_status;
  xlen_t mret_status;

  // Priority: trap_req, illegal access, mret, then the plain CSR write
  assign take_entry = trap_req | illegal;
  assign take_mret  = mret_req & ~take_entry;

  always_comb begin
    entry_status = regs.mstatus;
    entry_status[MSTATUS_MPIE_BIT] = regs.mstatus[MSTATUS_MIE_BIT];
    entry_status[MSTATUS_MIE_BIT] = 1'b0;
    entry_status[MSTATUS_MPP_LSB +: 2] = PRIV_M;
  end

  always_comb begin
    mret_status = regs.mstatus;
    mret_status[MSTATUS_MIE_BIT] = regs.mstatus[MSTATUS_MPIE_BIT];
    mret_status[MSTATUS_MPIE_BIT] = 1'b1;  // MPP stays M, no lower modes
  end

  assign regs.trap_wr     = take_entry;
  assign regs.mret_wr     = take_mret;
  assign regs.new_mstatus = take_entry ? entry_status : mret_status;
  assign regs.new_mepc    = instr_pc;
  assign regs.new_mcause  = trap_req ? trap_cause : CAUSE_ILLEGAL_INSTR;
  assign regs.new_mtval   = trap_req ? trap_tval : {52'd0, csr_addr};  // Bad address for CSR faults

  // Any redirect blocks the CSR write of the same cycle
  assign kill = take_entry | take_mret;

  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_valid <= 1'b0;
    end else begin
      redirect_valid <= take_entry | take_mret;
    end
  end

  // Target is latched together with the strobe
  always_ff @(posedge clk) begin
    if (take_entry) begin
      redirect_pc <= regs.mtvec & MTVEC_BASE_MASK;
    end else if (take_mret) begin
      redirect_pc <= regs.mepc;
    end
  end

endmodule

`default_nettype wire

//--- design/csr_unit_top.sv
// CSR subsystem top level
`default_nettype none

module csr_unit_top
  import csr_pkg::*, trap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      csr_valid,
  input  wire csr_op_t   csr_op,
  input  wire csr_addr_t csr_addr,
  input  wire xlen_t     csr_src,
  output xlen_t          csr_rdata,
  input  wire logic      trap_req,
  input  wire cause_t    trap_cause,
  input  wire xlen_t     trap_tval,
  input  wire xlen_t     instr_pc,
  input  wire logic      mret_req,
  output logic           redirect_valid,
  output xlen_t          redirect_pc
);

  logic  rd_hit;
  logic  rd_only;
  logic  wr_en;
  xlen_t wr_data;
  logic  illegal;
  logic  kill;

  csr_trap_if trap_bus ();

  csr_file u_csr_file (
    .clk     (clk),
    .rst     (rst),
    .rd_addr (csr_addr),
    .rd_data (csr_rdata),
    .rd_hit  (rd_hit),
    .rd_only (rd_only),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .kill    (kill),
    .trap    (trap_bus.reg_side)
  );

  // Old value comes straight from the read port
  csr_op_unit u_csr_op_unit (
    .csr_valid (csr_valid),
    .csr_op    (csr_op),
    .csr_src   (csr_src),
    .old_value (csr_rdata),
    .rd_hit    (rd_hit),
    .rd_only   (rd_only),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .illegal   (illegal)
  );

  trap_ctrl u_trap_ctrl (
    .clk            (clk),
    .rst            (rst),
    .trap_req       (trap_req),
    .mret_req       (mret_req),
    .illegal        (illegal),
    .trap_cause     (trap_cause),
    .instr_pc       (instr_pc),
    .trap_tval      (trap_tval),
    .csr_addr       (csr_addr),
    .kill           (kill),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .regs           (trap_bus.trap_side)
  );

endmodule

`default_nettype wire

//--- verification/csr_unit_chk.sv
// Redirect and kill assertions
`default_nettype none

module csr_unit_chk (
  input wire logic clk,
  input wire logic rst,
  input wire logic trap_req,
  input wire logic mret_req,
  input wire logic illegal,
  input wire logic kill,
  input wire logic redirect_valid
);

  // Redirect strobe is cleared by every reset cycle
  redirect_low_in_reset: assert property (@(posedge clk) rst |=> !redirect_valid)
    else $error("redirect_valid high after a reset cycle");

  // One request gives a single pulse
  redirect_single_pulse: assert property (
    @(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid
  ) else $error("redirect_valid high two cycles in a row");

  kill_has_cause: assert property (
    @(posedge clk) kill |-> (trap_req || illegal || mret_req)
  ) else $error("kill raised without a trap, an illegal access or an mret");

endmodule

`default_nettype wire

//--- verification/csr_unit_tb.sv
// CSR subsystem testbench
`default_nettype none

module csr_unit_tb
  import csr_pkg::*, trap_pkg::*;
();

  localparam int    CLK_PERIOD       = 40;
  localparam int    DRIVE_DELAY      = 2;
  localparam int    RST_CYCLES       = 4;
  localparam int    REDIRECT_TIMEOUT = 10;
  localparam int    MCYCLE_GAP       = 7;
  localparam int    RANDOM_OPS       = 40;
  localparam xlen_t MIE_MASK         = 64'd1 << MSTATUS_MIE_BIT;
  localparam xlen_t MPIE_MASK        = 64'd1 << MSTATUS_MPIE_BIT;

  logic      clk = 1'b0;
  logic      rst;
  logic      csr_valid;
  csr_op_t   csr_op;
  csr_addr_t csr_addr;
  xlen_t     csr_src;
  xlen_t     csr_rdata;
  logic      trap_req;
  cause_t    trap_cause;
  xlen_t     trap_tval;
  xlen_t     instr_pc;
  logic      mret_req;
  logic      redirect_valid;
  xlen_t     redirect_pc;

  logic  exp_check = 1'b0;  // Read value is checked this cycle
  xlen_t exp_rdata;

  integer seed     = 32'h98de_3656;
  int     tests    = 0;
  int     checks   = 0;
  int     errors   = 0;
  int     err_mark = 0;

  // Reference register state, starting from the reset values
  xlen_t  m_mstatus  = RST_MSTATUS;
  xlen_t  m_mie      = RST_MIE;
  xlen_t  m_mtvec    = '0;
  xlen_t  m_mscratch = '0;
  xlen_t  m_mepc     = '0;
  cause_t m_mcause   = '0;
  xlen_t  m_mtval    = '0;
  xlen_t  m_mip      = RST_MIP;
  xlen_t  m_mcycle   = '0;

  csr_addr_t wr_addrs [8] = '{ADDR_MSTATUS, ADDR_MIE, ADDR_MTVEC, ADDR_MSCRATCH,
                              ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP};
  csr_addr_t ro_addrs [5] = '{ADDR_MISA, ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID,
                              ADDR_MHARTID};
  csr_addr_t trap_addrs [4] = '{ADDR_MSTATUS, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL};

  always #(CLK_PERIOD / 2) clk = ~clk;

  csr_unit_top UUT (
    .clk            (clk),
    .rst            (rst),
    .csr_valid      (csr_valid),
    .csr_op         (csr_op),
    .csr_addr       (csr_addr),
    .csr_src        (csr_src),
    .csr_rdata      (csr_rdata),
    .trap_req       (trap_req),
    .trap_cause     (trap_cause),
    .trap_tval      (trap_tval),
    .instr_pc       (instr_pc),
    .mret_req       (mret_req),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  bind trap_ctrl csr_unit_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .trap_req       (trap_req),
    .mret_req       (mret_req),
    .illegal        (illegal),
    .kill           (kill),
    .redirect_valid (redirect_valid)
  );

  function automatic xlen_t read_model(input csr_addr_t addr);
    case (addr)
      ADDR_MSTATUS:  return m_mstatus;
      ADDR_MISA:     return MISA_VALUE;
      ADDR_MIE:      return m_mie;
      ADDR_MTVEC:    return m_mtvec;
      ADDR_MSCRATCH: return m_mscratch;
      ADDR_MEPC:     return m_mepc;
      ADDR_MCAUSE:   return m_mcause;
      ADDR_MTVAL:    return m_mtval;
      ADDR_MIP:      return m_mip;
      ADDR_MCYCLE:   return m_mcycle;
      default:       return '0;  // ID registers and unmapped addresses
    endcase
  endfunction

  function automatic xlen_t op_result(input csr_op_t op, input xlen_t old, input xlen_t src);
    case (op)
      CSR_OP_RW: return src;
      CSR_OP_RS: return old | src;
      CSR_OP_RC: return old & ~src;
      default:   return old;
    endcase
  endfunction

  // Trap entry goes to the mtvec base, mret to mepc
  function automatic xlen_t redirect_target(input logic is_mret);
    return is_mret ? m_mepc : (m_mtvec & MTVEC_BASE_MASK);
  endfunction

  task automatic update_model(input csr_addr_t addr, input xlen_t value);
    case (addr)
      ADDR_MSTATUS:  m_mstatus = value;
      ADDR_MIE:      m_mie = value;
      ADDR_MTVEC:    m_mtvec = value;
      ADDR_MSCRATCH: m_mscratch = value;
      ADDR_MEPC:     m_mepc = value;
      ADDR_MCAUSE:   m_mcause = value;
      ADDR_MTVAL:    m_mtval = value;
      ADDR_MIP:      m_mip = value;
      ADDR_MCYCLE:   m_mcycle = value;
      default:       ;
    endcase
  endtask

  task automatic trap_entry(input cause_t cause, input xlen_t pc, input xlen_t tval);
    m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
    m_mstatus[MSTATUS_MIE_BIT] = 1'b0;
    m_mstatus[MSTATUS_MPP_LSB +: 2] = PRIV_M;
    m_mepc = pc;
    m_mcause = cause;
    m_mtval = tval;
  endtask

  task automatic mret_return();
    m_mstatus[MSTATUS_MIE_BIT] = m_mstatus[MSTATUS_MPIE_BIT];
    m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
  endtask

  task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %0s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_redirect(input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: redirect_pc %h, expected %h", $time, got, exp);
    end
  endtask

  // Sampled mid-cycle, well away from the input changes
  always @(negedge clk) begin
    if (exp_check) begin
      check_xlen($sformatf("csr 0x%h", csr_addr), csr_rdata, exp_rdata);
    end
  end

  // Entered and left a short delay after a rising edge
  task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input xlen_t src,
                            input logic check, input xlen_t exp_old);
    csr_valid = 1'b1;
    csr_op = op;
    csr_addr = addr;
    csr_src = src;
    exp_rdata = exp_old;
    exp_check = check;
    @(posedge clk);
    #DRIVE_DELAY;
    csr_valid = 1'b0;
    csr_op = CSR_OP_RD;
    exp_check = 1'b0;
  endtask

  task automatic rmw_and_verify(input csr_op_t op, input csr_addr_t addr, input xlen_t src);
    xlen_t old;
    old = read_model(addr);
    csr_access(op, addr, src, 1'b1, old);
    update_model(addr, op_result(op, old, src));
    csr_access(CSR_OP_RD, addr, '0, 1'b1, read_model(addr));
  endtask

  task automatic wait_redirect(input xlen_t exp_pc);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!redirect_valid && cycles < REDIRECT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!redirect_valid) begin
      errors++;
      $display("timeout at %0t: no redirect within %0d cycles", $time, REDIRECT_TIMEOUT);
      report_and_finish();
    end else begin
      if (cycles != 0) begin
        errors++;
        $display("redirect at %0t came %0d cycles late", $time, cycles);
      end
      check_redirect(redirect_pc, exp_pc);
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_trap_regs();
    foreach (trap_addrs[i]) begin
      csr_access(CSR_OP_RD, trap_addrs[i], '0, 1'b1, read_model(trap_addrs[i]));
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("test %0s: ok", name);
    end else begin
      $display("test %0s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic report_and_finish();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    xlen_t   src;
    xlen_t   first;
    xlen_t   target;
    csr_op_t op;
    int      idx;

    rst = 1'b1;
    csr_valid = 1'b0;
    csr_op = CSR_OP_RD;
    csr_addr = '0;
    csr_src = '0;
    trap_req = 1'b0;
    trap_cause = '0;
    trap_tval = '0;
    instr_pc = '0;
    mret_req = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    foreach (wr_addrs[i]) begin
      csr_access(CSR_OP_RD, wr_addrs[i], '0, 1'b1, read_model(wr_addrs[i]));
    end
    foreach (ro_addrs[i]) begin
      csr_access(CSR_OP_RD, ro_addrs[i], '0, 1'b1, read_model(ro_addrs[i]));
    end
    end_test("reset values");

    for (int i = 0; i < RANDOM_OPS; i++) begin
      idx = $unsigned($random(seed)) % 8;
      op = csr_op_t'($unsigned($random(seed)) % 3);
      src = {$random(seed), $random(seed)};
      if (i % 8 == 7) src = '0;  // Zero operand, set and clear only read
      rmw_and_verify(op, wr_addrs[idx], src);
    end
    end_test("random csr ops");

    // Hold a read of mcycle and sample it twice
    csr_valid = 1'b1;
    csr_op = CSR_OP_RD;
    csr_addr = ADDR_MCYCLE;
    @(negedge clk);
    first = csr_rdata;
    repeat (MCYCLE_GAP) @(negedge clk);
    check_xlen("mcycle delta", csr_rdata - first, xlen_t'(MCYCLE_GAP));
    @(posedge clk);
    #DRIVE_DELAY;
    csr_valid = 1'b0;
    src = {$random(seed), $random(seed)};
    csr_access(CSR_OP_RW, ADDR_MCYCLE, src, 1'b0, '0);
    update_model(ADDR_MCYCLE, src);
    csr_access(CSR_OP_RD, ADDR_MCYCLE, '0, 1'b1, read_model(ADDR_MCYCLE));
    end_test("mcycle");

    rmw_and_verify(CSR_OP_RW, ADDR_MTVEC, {$random(seed), $random(seed)});
    rmw_and_verify(CSR_OP_RW, ADDR_MSTATUS, MIE_MASK);  // MIE alone set so every entry field changes
    target = redirect_target(1'b0);
    trap_req = 1'b1;
    trap_cause = 64'd11;
    instr_pc = {$random(seed), $random(seed)};
    trap_tval = {$random(seed), $random(seed)};
    trap_entry(trap_cause, instr_pc, trap_tval);
    @(posedge clk);
    #DRIVE_DELAY;
    trap_req = 1'b0;
    wait_redirect(target);
    check_trap_regs();
    end_test("trap entry");

    instr_pc = {$random(seed), $random(seed)};
    target = redirect_target(1'b0);
    csr_access(CSR_OP_RW, ADDR_MVENDORID, {$random(seed), $random(seed)}, 1'b1, '0);
    trap_entry(CAUSE_ILLEGAL_INSTR, instr_pc, {52'd0, ADDR_MVENDORID});
    wait_redirect(target);
    csr_access(CSR_OP_RD, ADDR_MVENDORID, '0, 1'b1, read_model(ADDR_MVENDORID));
    check_trap_regs();
    instr_pc = {$random(seed), $random(seed)};
    target = redirect_target(1'b0);
    csr_access(CSR_OP_RD, 12'h7C0, '0, 1'b1, '0);  // Unmapped
    trap_entry(CAUSE_ILLEGAL_INSTR, instr_pc, 64'h7C0);
    wait_redirect(target);
    check_trap_regs();
    end_test("illegal access");

    rmw_and_verify(CSR_OP_RW, ADDR_MEPC, {$random(seed), $random(seed)});
    rmw_and_verify(CSR_OP_RC, ADDR_MSTATUS, MIE_MASK);
    rmw_and_verify(CSR_OP_RS, ADDR_MSTATUS, MPIE_MASK);
    target = redirect_target(1'b1);
    mret_req = 1'b1;
    instr_pc = {$random(seed), $random(seed)};
    mret_return();
    @(posedge clk);
    #DRIVE_DELAY;
    mret_req = 1'b0;
    wait_redirect(target);
    csr_access(CSR_OP_RD, ADDR_MSTATUS, '0, 1'b1, read_model(ADDR_MSTATUS));
    csr_access(CSR_OP_RD, ADDR_MEPC, '0, 1'b1, read_model(ADDR_MEPC));
    end_test("mret");

    report_and_finish();
  end

endmodule

`default_nettype wire

//--- tb.f
common/csr_pkg.sv
common/trap_pkg.sv
common/csr_trap_if.sv
csr/csr_file.sv
csr/csr_op_unit.sv
design/trap_ctrl.sv
design/csr_unit_top.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

//--- Makefile
# Verilator simulation of the CSR subsystem

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run fails on a nonzero exit status or on the fail message in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "Verification failed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
